/* source/mem_sys_defs.svh */
// ====================
// Sizes and base address of the shared memory subsystem
// Included by the package, the RTL and the testbench
// ====================

`ifndef MEM_SYS_DEFS_SVH
`define MEM_SYS_DEFS_SVH

// Byte address and data word widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// RAM size in words
`define MEM_DEPTH_WORDS 256

// Word index width into the RAM
`define MEM_WADDR_W $clog2(`MEM_DEPTH_WORDS)

// Base byte address of the RAM window
`define MEM_BOOT_ADDR 32'h0000_0000

`endif

/* source/mem_sys_pkg.sv */
// ====================
// Shared types of the memory subsystem
// Imported by the RTL modules and the testbench
// ====================

`include "mem_sys_defs.svh"

package mem_sys_pkg;

  typedef logic [`MEM_DATA_W-1:0]   word_t;
  typedef logic [`MEM_ADDR_W-1:0]   addr_t;
  typedef logic [`MEM_DATA_W/8-1:0] be_t;

  // Fetch payload, reads only
  typedef struct packed {
    addr_t addr;
  } instr_req_t;

  // Load/store payload
  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    word_t wdata;
  } data_req_t;

  // Owner of a RAM access
  typedef enum logic {
    PORT_INSTR = 1'b0,
    PORT_DATA  = 1'b1
  } port_e;

endpackage

/* source/mem_req_slice.sv */
// ====================
// One-entry request buffer between a host port and the arbiter
// Grants whenever the entry is free or leaves in the same cycle
// ====================

module mem_req_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,

  // Host side
  input  logic     req_i,
  input  payload_t payload_i,
  output logic     gnt_o,

  // Arbiter side
  output logic     valid_o,
  output payload_t payload_o,
  input  logic     pop_i
);

  logic     valid_q;
  payload_t payload_q;
  logic     load;

  // Free slot, or slot being emptied this cycle
  assign gnt_o = ~valid_q | pop_i;
  assign load  = req_i & gnt_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (pop_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload captured on the grant cycle
  always_ff @(posedge clk_i) begin
    if (load) begin
      payload_q <= payload_i;
    end
  end

  assign valid_o   = valid_q;
  assign payload_o = payload_q;

endmodule

/* source/mem_arbiter.sv */
// ====================
// Round-robin arbiter from the two request buffers onto the single RAM port
// Checks the address range and routes each response back to its owner
// ====================

`include "mem_sys_defs.svh"

module mem_arbiter import mem_sys_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  // Fetch buffer
  input  logic                    instr_valid_i,
  input  instr_req_t              instr_req_i,
  output logic                    instr_pop_o,

  // Load/store buffer
  input  logic                    data_valid_i,
  input  data_req_t               data_req_i,
  output logic                    data_pop_o,

  // RAM port
  output logic                    ram_en_o,
  output logic                    ram_we_o,
  output be_t                     ram_be_o,
  output logic [`MEM_WADDR_W-1:0] ram_waddr_o,
  output word_t                   ram_wdata_o,
  input  logic                    ram_rvalid_i,
  input  word_t                   ram_rdata_i,

  // Fetch response
  output logic                    instr_rvalid_o,
  output logic                    instr_err_o,
  output word_t                   instr_rdata_o,

  // Load/store response
  output logic                    data_rvalid_o,
  output logic                    data_err_o,
  output word_t                   data_rdata_o
);

  // Size of the RAM window in bytes
  localparam addr_t ram_bytes = addr_t'(4 * `MEM_DEPTH_WORDS);

  logic  pick_instr;
  logic  pick_data;
  logic  pick_any;
  port_e sel_port;
  addr_t sel_addr;
  addr_t offset;
  logic  in_range;

  // Owner of the access in flight and last-served pointer
  port_e owner_q;
  logic  err_q;

  logic  rsp_valid;
  word_t rsp_rdata;

  // Data wins unless fetch is waiting and data went last
  assign pick_data  = data_valid_i & (~instr_valid_i | (owner_q == PORT_INSTR));
  assign pick_instr = instr_valid_i & ~pick_data;
  assign pick_any   = pick_instr | pick_data;
  assign sel_port   = pick_data ? PORT_DATA : PORT_INSTR;

  assign instr_pop_o = pick_instr;
  assign data_pop_o  = pick_data;

  // Range check against the RAM window
  assign sel_addr = pick_data ? data_req_i.addr : instr_req_i.addr;
  assign offset   = sel_addr - `MEM_BOOT_ADDR;
  assign in_range = offset < ram_bytes;

  // Out-of-range requests never reach the RAM
  assign ram_en_o    = pick_any & in_range;
  assign ram_we_o    = pick_data & data_req_i.we;
  assign ram_be_o    = pick_data ? data_req_i.be : '1;
  assign ram_waddr_o = offset[`MEM_WADDR_W+1:2];
  assign ram_wdata_o = data_req_i.wdata;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      owner_q <= PORT_INSTR;
      err_q   <= 1'b0;
    end else begin
      err_q <= pick_any & ~in_range;
      if (pick_any) begin
        owner_q <= sel_port;
      end
    end
  end

  // Errors answer locally while RAM accesses answer one cycle later
  assign rsp_valid = err_q | ram_rvalid_i;
  assign rsp_rdata = err_q ? '0 : ram_rdata_i;

  assign instr_rvalid_o = rsp_valid & (owner_q == PORT_INSTR);
  assign instr_err_o    = instr_rvalid_o & err_q;
  assign instr_rdata_o  = rsp_rdata;

  assign data_rvalid_o = rsp_valid & (owner_q == PORT_DATA);
  assign data_err_o    = data_rvalid_o & err_q;
  assign data_rdata_o  = rsp_rdata;

endmodule

/* source/mem_ram.sv */
// ====================
// Single-port synchronous RAM with byte-enable writes
// Every access answers with rvalid one cycle later
// ====================

`include "mem_sys_defs.svh"

module mem_ram import mem_sys_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    en_i,
  input  logic                    we_i,
  input  be_t                     be_i,
  input  logic [`MEM_WADDR_W-1:0] addr_i,
  input  word_t                   wdata_i,
  output logic                    rvalid_o,
  output word_t                   rdata_o
);

  word_t mem_q [`MEM_DEPTH_WORDS];
  word_t rdata_q;
  logic  rvalid_q;

  // Contents start cleared at time zero
  initial begin
    for (int i = 0; i < `MEM_DEPTH_WORDS; i++) begin
      mem_q[i] = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < $bits(be_t); b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
      // Old word on a write as well
      rdata_q <= mem_q[addr_i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= en_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

/* source/mem_sys_top.sv */
// ====================
// Memory subsystem top with fetch and load/store host ports
// Two request buffers feed one arbiter in front of the RAM
// ====================

`include "mem_sys_defs.svh"

module mem_sys_top import mem_sys_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,

  // Instruction fetch port
  input  logic  instr_req_i,
  output logic  instr_gnt_o,
  input  addr_t instr_addr_i,
  output logic  instr_rvalid_o,
  output word_t instr_rdata_o,
  output logic  instr_err_o,

  // Load/store port
  input  logic  data_req_i,
  output logic  data_gnt_o,
  input  addr_t data_addr_i,
  input  logic  data_we_i,
  input  be_t   data_be_i,
  input  word_t data_wdata_i,
  output logic  data_rvalid_o,
  output word_t data_rdata_o,
  output logic  data_err_o
);

  instr_req_t instr_req;
  instr_req_t instr_entry;
  logic       instr_valid;
  logic       instr_pop;

  data_req_t  data_req;
  data_req_t  data_entry;
  logic       data_valid;
  logic       data_pop;

  logic                    ram_en;
  logic                    ram_we;
  be_t                     ram_be;
  logic [`MEM_WADDR_W-1:0] ram_waddr;
  word_t                   ram_wdata;
  logic                    ram_rvalid;
  word_t                   ram_rdata;

  // Pack host fields into payloads
  assign instr_req = '{addr: instr_addr_i};
  assign data_req  = '{addr: data_addr_i, we: data_we_i, be: data_be_i, wdata: data_wdata_i};

  mem_req_slice #(
    .payload_t (instr_req_t)
  ) i_instr_slice (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (instr_req_i),
    .payload_i (instr_req),
    .gnt_o     (instr_gnt_o),
    .valid_o   (instr_valid),
    .payload_o (instr_entry),
    .pop_i     (instr_pop)
  );

  mem_req_slice #(
    .payload_t (data_req_t)
  ) i_data_slice (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (data_req_i),
    .payload_i (data_req),
    .gnt_o     (data_gnt_o),
    .valid_o   (data_valid),
    .payload_o (data_entry),
    .pop_i     (data_pop)
  );

  mem_arbiter i_arbiter (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .instr_valid_i  (instr_valid),
    .instr_req_i    (instr_entry),
    .instr_pop_o    (instr_pop),
    .data_valid_i   (data_valid),
    .data_req_i     (data_entry),
    .data_pop_o     (data_pop),
    .ram_en_o       (ram_en),
    .ram_we_o       (ram_we),
    .ram_be_o       (ram_be),
    .ram_waddr_o    (ram_waddr),
    .ram_wdata_o    (ram_wdata),
    .ram_rvalid_i   (ram_rvalid),
    .ram_rdata_i    (ram_rdata),
    .instr_rvalid_o (instr_rvalid_o),
    .instr_err_o    (instr_err_o),
    .instr_rdata_o  (instr_rdata_o),
    .data_rvalid_o  (data_rvalid_o),
    .data_err_o     (data_err_o),
    .data_rdata_o   (data_rdata_o)
  );

  mem_ram i_ram (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .en_i     (ram_en),
    .we_i     (ram_we),
    .be_i     (ram_be),
    .addr_i   (ram_waddr),
    .wdata_i  (ram_wdata),
    .rvalid_o (ram_rvalid),
    .rdata_o  (ram_rdata)
  );

endmodule

/* tests/tb_clk_gen.sv */
// ====================
// Clock and reset source for the testbench
// ====================

module tb_clk_gen #(
  parameter int unsigned period_ns  = 20,
  parameter int unsigned rst_cycles = 10
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (rst_cycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* tests/mem_sys_props.sv */
// ====================
// Host port protocol assertions bound into the memory subsystem top
// ====================

module mem_sys_props import mem_sys_pkg::*; (
  input logic  clk_i,
  input logic  rst_n_i,
  input logic  instr_req_i,
  input logic  instr_gnt_o,
  input logic  instr_rvalid_o,
  input logic  instr_err_o,
  input word_t instr_rdata_o,
  input logic  data_req_i,
  input logic  data_gnt_o,
  input logic  data_rvalid_o,
  input logic  data_err_o,
  input word_t data_rdata_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [1:0] grant;
  logic [1:0] rvalid;
  logic [1:0] zero_err;

  assign grant[PORT_INSTR]    = instr_req_i & instr_gnt_o;
  assign grant[PORT_DATA]     = data_req_i & data_gnt_o;
  assign rvalid[PORT_INSTR]   = instr_rvalid_o;
  assign rvalid[PORT_DATA]    = data_rvalid_o;
  assign zero_err[PORT_INSTR] = ~instr_err_o | (instr_rdata_o == '0);
  assign zero_err[PORT_DATA]  = ~data_err_o | (data_rdata_o == '0);

  for (genvar p = 0; p < 2; p++) begin : g_port
    // Grants still waiting for their response
    logic [2:0] outstanding;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        outstanding <= '0;
      end else begin
        outstanding <= outstanding + 3'(grant[p]) - 3'(rvalid[p]);
      end
    end

    a_no_orphan: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rvalid[p] |-> outstanding != '0)
      else $error("Port %0d gave rvalid with no grant outstanding", p);

    a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $past(grant[p], 3) |-> rvalid[p] || $past(rvalid[p]))
      else $error("Port %0d grant got no rvalid within 3 cycles", p);

    a_err_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      zero_err[p])
      else $error("Port %0d err response with nonzero rdata", p);
  end

endmodule

bind mem_sys_top mem_sys_props i_props (.*);

/* tests/mem_sys_tb_top.sv */
// ====================
// Random fetch and load/store traffic against a word model of the RAM
// Two phases swap the regions, so fetches also read stored data
// ====================

`include "mem_sys_defs.svh"

module mem_sys_tb_top import mem_sys_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned clk_ns       = 20;
  localparam int unsigned n_req        = 60;
  localparam int unsigned region_words = 32;
  localparam int unsigned watchdog_ns  = (4 * n_req * 3 + 10 + 200) * clk_ns;
  localparam addr_t       ram_bytes    = addr_t'(4 * `MEM_DEPTH_WORDS);

  typedef struct {
    addr_t       addr;
    word_t       rdata;
    logic        err;
    logic        chk;
    int unsigned cyc;
  } exp_t;

  logic  clk, rst_n;
  logic  instr_req, instr_gnt, instr_rvalid, instr_err;
  addr_t instr_addr;
  word_t instr_rdata;
  logic  data_req, data_gnt, data_rvalid, data_err, data_we;
  addr_t data_addr;
  be_t   data_be;
  word_t data_wdata, data_rdata;

  word_t       model_mem [`MEM_DEPTH_WORDS];
  exp_t        instr_q [$];
  exp_t        data_q [$];
  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned cyc = 0;

  tb_clk_gen #(.period_ns(clk_ns), .rst_cycles(10)) i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  mem_sys_top i_dut (
    .clk_i (clk), .rst_n_i (rst_n),
    .instr_req_i (instr_req), .instr_gnt_o (instr_gnt), .instr_addr_i (instr_addr),
    .instr_rvalid_o (instr_rvalid), .instr_rdata_o (instr_rdata), .instr_err_o (instr_err),
    .data_req_i (data_req), .data_gnt_o (data_gnt), .data_addr_i (data_addr),
    .data_we_i (data_we), .data_be_i (data_be), .data_wdata_i (data_wdata),
    .data_rvalid_o (data_rvalid), .data_rdata_o (data_rdata), .data_err_o (data_err)
  );

  always @(posedge clk) cyc <= cyc + 1;

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  function automatic addr_t word_addr(input int unsigned idx);
    return `MEM_BOOT_ADDR + addr_t'(4 * idx);
  endfunction

  // Expected answer of a granted request with the model updated in grant order
  task automatic model_access(input addr_t addr, input logic we, input be_t be,
                              input word_t wdata, output exp_t exp);
    addr_t                   off;
    logic [`MEM_WADDR_W-1:0] idx;
    off = addr - `MEM_BOOT_ADDR;
    idx = off[`MEM_WADDR_W+1:2];
    exp.addr = addr;
    exp.cyc  = cyc;
    exp.err  = (off >= ram_bytes);
    exp.chk  = exp.err | ~we;
    exp.rdata = exp.err ? '0 : model_mem[idx];
    if (!exp.err && we) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) model_mem[idx][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endtask

  task automatic check_response(input string port, input exp_t exp, input word_t rdata,
                                input logic err);
    check_err($sformatf("%s err @%08h", port, exp.addr), exp.err, err);
    if (exp.chk) check_word($sformatf("%s rdata @%08h", port, exp.addr), exp.rdata, rdata);
    if (cyc - exp.cyc < 2 || cyc - exp.cyc > 3) begin
      errors++;
      $display("%s response @%08h came %0d cycles after its grant, not 2 to 3",
               port, exp.addr, cyc - exp.cyc);
    end
  endtask

  task automatic fetch_traffic(input int unsigned n, input int unsigned base_word);
    exp_t  exp;
    addr_t addr;
    for (int unsigned i = 0; i < n; i++) begin
      @(negedge clk);
      if ($urandom_range(0, 3) == 0) begin
        instr_req = 1'b0;
        repeat ($urandom_range(1, 2)) @(negedge clk);
      end
      addr = word_addr(base_word + $urandom_range(0, region_words - 1));
      // Rare fetch outside the RAM window that aliases a real word
      if ($urandom_range(0, 11) == 0) addr = addr + ram_bytes * addr_t'($urandom_range(1, 4));
      instr_addr = addr;
      instr_req  = 1'b1;
      while (!instr_gnt) @(negedge clk);
      model_access(addr, 1'b0, '0, '0, exp);
      instr_q.push_back(exp);
    end
    @(negedge clk);
    instr_req = 1'b0;
  endtask

  task automatic data_traffic(input int unsigned n, input int unsigned base_word);
    exp_t  exp;
    addr_t addr;
    logic  we;
    logic  last_we;
    last_we = 1'b0;
    addr    = word_addr(base_word);
    for (int unsigned i = 0; i < n; i++) begin
      @(negedge clk);
      if ($urandom_range(0, 3) == 0) begin
        data_req = 1'b0;
        repeat ($urandom_range(1, 2)) @(negedge clk);
      end
      // Often read back the word just written
      if (last_we && $urandom_range(0, 1) == 1) begin
        we = 1'b0;
      end else begin
        addr = word_addr(base_word + $urandom_range(0, region_words - 1));
        if ($urandom_range(0, 15) == 0) addr = addr + ram_bytes * addr_t'($urandom_range(1, 4));
        we = ($urandom_range(0, 1) == 1);
      end
      data_addr  = addr;
      data_we    = we;
      data_be    = be_t'($urandom_range(0, 15));
      data_wdata = $urandom();
      data_req   = 1'b1;
      while (!data_gnt) @(negedge clk);
      model_access(addr, we, data_be, data_wdata, exp);
      data_q.push_back(exp);
      last_we = we;
    end
    @(negedge clk);
    data_req = 1'b0;
  endtask

  task automatic drain_responses();
    int unsigned n;
    n = 0;
    while ((instr_q.size() != 0 || data_q.size() != 0) && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (instr_q.size() != 0 || data_q.size() != 0) begin
      errors++;
      $display("Responses missing: %0d fetch and %0d load/store never answered",
               instr_q.size(), data_q.size());
      instr_q.delete();
      data_q.delete();
    end
  endtask

  // Responses checked mid-cycle where the outputs are settled
  always @(negedge clk) begin
    if (rst_n && instr_rvalid) begin
      if (instr_q.size() == 0) begin
        errors++;
        $display("Fetch response at cycle %0d has no grant waiting for it", cyc);
      end else begin
        check_response("fetch", instr_q.pop_front(), instr_rdata, instr_err);
      end
    end
    if (rst_n && data_rvalid) begin
      if (data_q.size() == 0) begin
        errors++;
        $display("Load/store response at cycle %0d has no grant waiting for it", cyc);
      end else begin
        check_response("data", data_q.pop_front(), data_rdata, data_err);
      end
    end
  end

  initial begin
    void'($urandom(32'h03cc_7498));
    instr_req  = 1'b0;
    instr_addr = '0;
    data_req   = 1'b0;
    data_addr  = '0;
    data_we    = 1'b0;
    data_be    = '0;
    data_wdata = '0;
    for (int i = 0; i < `MEM_DEPTH_WORDS; i++) model_mem[i] = '0;
    @(posedge rst_n);
    repeat (3) begin
      @(negedge clk);
      check_flag("instr_gnt idle", 1'b1, instr_gnt);
      check_flag("data_gnt idle", 1'b1, data_gnt);
      check_flag("instr_rvalid idle", 1'b0, instr_rvalid);
      check_flag("data_rvalid idle", 1'b0, data_rvalid);
      check_err("instr_err idle", 1'b0, instr_err);
      check_err("data_err idle", 1'b0, data_err);
    end
    // Stores into the low region while fetches read the high one
    fork
      fetch_traffic(n_req, 128);
      data_traffic(n_req, 0);
    join
    drain_responses();
    fork
      fetch_traffic(n_req, 0);
      data_traffic(n_req, 128);
    join
    drain_responses();
    repeat (4) @(negedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns, traffic never completed", watchdog_ns);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+source
source/mem_sys_pkg.sv
source/mem_req_slice.sv
source/mem_arbiter.sv
source/mem_ram.sv
source/mem_sys_top.sv
tests/tb_clk_gen.sv
tests/mem_sys_props.sv
tests/mem_sys_tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the memory subsystem testbench with Verilator and runs it.
# Exit status is zero only when the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module mem_sys_tb_top -f verilog.f -o mem_sys_sim || exit 1

result=$(./obj_dir/mem_sys_sim)
echo "$result"

echo "$result" | grep -qxF '** PASS **' && echo "Simulation passed" || {
  echo "Simulation failed"
  exit 1
}
